// ==== source/eeprom_pkg.sv ====
`default_nettype none

package eeprom_pkg;

    typedef logic [10:0] ee_addr_t;    // byte address in a 24C16-class part
    typedef logic [7:0]  ee_byte_t;
    typedef logic [3:0]  axil_addr_t;
    typedef logic [31:0] axil_data_t;

    typedef enum logic
    {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } cmd_op_t;

    localparam axil_addr_t REG_ADDR   = 4'h0;
    localparam axil_addr_t REG_WDATA  = 4'h4;
    localparam axil_addr_t REG_CTRL   = 4'h8;
    localparam axil_addr_t REG_STATUS = 4'hC;

    // upper nibble of every control byte
    localparam logic [3:0] DEV_CODE = 4'b1010;

endpackage

`default_nettype wire

// ==== source/eeprom_cmd_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface eeprom_cmd_if;
    logic                 cmd_valid;
    logic                 cmd_ready;
    eeprom_pkg::cmd_op_t  cmd_op;
    eeprom_pkg::ee_addr_t cmd_addr;
    eeprom_pkg::ee_byte_t cmd_wdata;
    logic                 done_pulse;   // one cycle, end of stop
    logic                 done_nack;
    eeprom_pkg::ee_byte_t done_rdata;

    modport decode (output cmd_valid, cmd_op, cmd_addr, cmd_wdata, input cmd_ready);
    modport engine (input cmd_valid, cmd_op, cmd_addr, cmd_wdata,
                    output cmd_ready, done_pulse, done_nack, done_rdata);
    modport result (input cmd_valid, cmd_ready, cmd_op, done_pulse, done_nack, done_rdata);
endinterface

`default_nettype wire

// ==== source/axil_reg_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module axil_reg_decode (
    input  logic                   CLK,
    input  logic                   RESET,
    input  eeprom_pkg::axil_addr_t s_awaddr,
    input  logic                   s_awvalid,
    output logic                   s_awready,
    input  eeprom_pkg::axil_data_t s_wdata,
    input  logic [3:0]             s_wstrb,
    input  logic                   s_wvalid,
    output logic                   s_wready,
    output logic [1:0]             s_bresp,
    output logic                   s_bvalid,
    input  logic                   s_bready,
    input  eeprom_pkg::axil_addr_t s_araddr,
    input  logic                   s_arvalid,
    output logic                   s_arready,
    output eeprom_pkg::axil_data_t s_rdata,
    output logic [1:0]             s_rresp,
    output logic                   s_rvalid,
    input  logic                   s_rready,
    eeprom_cmd_if.decode           cmd,
    input  logic                   st_busy,
    input  logic                   st_done,
    input  logic                   st_nack,
    input  eeprom_pkg::ee_byte_t   st_rdata,
    output logic                   st_clear
);
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    eeprom_pkg::ee_addr_t   addr_reg;
    eeprom_pkg::ee_byte_t   wdata_reg;
    eeprom_pkg::axil_data_t rd_word;
    logic                   wr_hs;
    logic                   rd_hs;
    logic                   start_req;
    logic                   cmd_busy;

    assign wr_hs     = s_awready && s_awvalid && s_wready && s_wvalid;
    assign rd_hs     = s_arready && s_arvalid;
    assign start_req = (s_awaddr == eeprom_pkg::REG_CTRL) && s_wstrb[0]
                       && (s_wdata[0] || s_wdata[1]);
    assign cmd_busy  = cmd.cmd_valid || st_busy;    // pending or on the bus
    assign st_clear  = rd_hs && (s_araddr == eeprom_pkg::REG_STATUS);
    assign s_rresp   = RESP_OKAY;

    assign cmd.cmd_addr  = addr_reg;
    assign cmd.cmd_wdata = wdata_reg;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            s_awready     <= 1'b0;
            s_wready      <= 1'b0;
            s_bvalid      <= 1'b0;
            s_arready     <= 1'b0;
            s_rvalid      <= 1'b0;
            cmd.cmd_valid <= 1'b0;
        end
        else
        begin
            // aw and w taken together, none while a response waits
            s_awready <= s_awvalid && s_wvalid && !s_awready && !s_bvalid;
            s_wready  <= s_awvalid && s_wvalid && !s_awready && !s_bvalid;
            if (wr_hs)
                s_bvalid <= 1'b1;
            else if (s_bready)
                s_bvalid <= 1'b0;

            s_arready <= s_arvalid && !s_arready && !s_rvalid;
            if (rd_hs)
                s_rvalid <= 1'b1;
            else if (s_rready)
                s_rvalid <= 1'b0;

            if (cmd.cmd_valid && cmd.cmd_ready)
                cmd.cmd_valid <= 1'b0;
            else if (wr_hs && start_req && !cmd_busy)
                cmd.cmd_valid <= 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (wr_hs)
        begin
            s_bresp <= (start_req && cmd_busy) ? RESP_SLVERR : RESP_OKAY;
            case (s_awaddr)
                eeprom_pkg::REG_ADDR:
                begin
                    if (s_wstrb[0])
                        addr_reg[7:0] <= s_wdata[7:0];
                    if (s_wstrb[1])
                        addr_reg[10:8] <= s_wdata[10:8];
                end
                eeprom_pkg::REG_WDATA:
                    if (s_wstrb[0])
                        wdata_reg <= s_wdata[7:0];
                eeprom_pkg::REG_CTRL:
                    if (start_req && !cmd_busy)     // write bit wins over read
                        cmd.cmd_op <= s_wdata[0] ? eeprom_pkg::OP_WRITE : eeprom_pkg::OP_READ;
                default: ;
            endcase
        end
        if (rd_hs)
            s_rdata <= rd_word;
    end

    always_comb
    begin
        rd_word = '0;
        case (s_araddr)
            eeprom_pkg::REG_ADDR:   rd_word[10:0] = addr_reg;
            eeprom_pkg::REG_WDATA:  rd_word[7:0] = wdata_reg;
            eeprom_pkg::REG_STATUS: rd_word = {16'h0, st_rdata, 5'h0, st_nack, st_done, st_busy};
            default: ;    // ctrl reads as zero
        endcase
    end

endmodule

`default_nettype wire

// ==== source/twi_bit_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module twi_bit_engine #(
    parameter int CLK_DIV = 4
) (
    input  logic         CLK,
    input  logic         RESET,
    eeprom_cmd_if.engine cmd,
    output logic         scl,
    output logic         sda_oe,
    input  logic         sda_in
);
    localparam int CW = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
    localparam logic [CW-1:0] LAST = CW'(CLK_DIV - 1);
    localparam logic [CW-1:0] MID  = CW'(CLK_DIV / 2);

    typedef enum logic [2:0]
    {
        S_IDLE,
        S_START,
        S_BYTE_OUT,
        S_ACK_IN,
        S_RESTART,
        S_BYTE_IN,
        S_NACK_OUT,
        S_STOP
    } state_t;

    state_t               state;
    logic [CW-1:0]        div_cnt;
    logic                 phase;        // 0 scl low half, 1 scl high half
    logic [2:0]           bit_cnt;
    logic [1:0]           byte_idx;
    logic                 nack_q;
    logic                 done_q;
    eeprom_pkg::cmd_op_t  op_q;
    eeprom_pkg::ee_addr_t addr_q;
    eeprom_pkg::ee_byte_t wdata_q;
    eeprom_pkg::ee_byte_t shreg;
    logic                 accept;
    logic                 half_end;
    logic                 mid;
    logic                 slot_end;

    assign accept   = (state == S_IDLE) && cmd.cmd_valid;
    assign half_end = (state != S_IDLE) && (div_cnt == LAST);
    assign mid      = (state != S_IDLE) && (div_cnt == MID);
    assign slot_end = half_end && phase;

    assign cmd.cmd_ready  = (state == S_IDLE);
    assign cmd.done_pulse = done_q;
    assign cmd.done_nack  = nack_q;
    assign cmd.done_rdata = shreg;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= S_IDLE;
            div_cnt  <= '0;
            phase    <= 1'b0;
            bit_cnt  <= '0;
            byte_idx <= '0;
            nack_q   <= 1'b0;
            done_q   <= 1'b0;
            scl      <= 1'b1;
            sda_oe   <= 1'b0;
        end
        else
        begin
            done_q <= 1'b0;
            if (state == S_IDLE)
            begin
                div_cnt <= '0;
                phase   <= 1'b0;
                if (accept)
                begin
                    state    <= S_START;
                    bit_cnt  <= '0;
                    byte_idx <= '0;
                    nack_q   <= 1'b0;
                end
            end
            else
            begin
                div_cnt <= half_end ? '0 : div_cnt + 1'b1;
                if (half_end)
                begin
                    phase <= ~phase;
                    scl   <= phase ? (state == S_STOP) : 1'b1;   // low next slot unless done
                end

                // sda moves mid half; while scl high only for start and stop
                if (mid)
                begin
                    case (state)
                        S_START, S_RESTART: sda_oe <= phase;
                        S_BYTE_OUT: if (!phase) sda_oe <= ~shreg[7];
                        S_STOP:     sda_oe <= ~phase;
                        default:    if (!phase) sda_oe <= 1'b0;
                    endcase
                end

                if (slot_end)
                begin
                    case (state)
                        S_START, S_RESTART: state <= S_BYTE_OUT;
                        S_BYTE_OUT, S_BYTE_IN:
                        begin
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == 3'd7)
                                state <= (state == S_BYTE_OUT) ? S_ACK_IN : S_NACK_OUT;
                        end
                        S_ACK_IN:
                        begin
                            if (sda_in)
                                nack_q <= 1'b1;     // sticky, keep going to stop
                            byte_idx <= byte_idx + 1'b1;
                            if (byte_idx == 2'd0)
                                state <= S_BYTE_OUT;
                            else if (byte_idx == 2'd1)
                                state <= (op_q == eeprom_pkg::OP_READ) ? S_RESTART : S_BYTE_OUT;
                            else
                                state <= (op_q == eeprom_pkg::OP_READ) ? S_BYTE_IN : S_STOP;
                        end
                        S_NACK_OUT: state <= S_STOP;
                        S_STOP:
                        begin
                            state  <= S_IDLE;
                            done_q <= 1'b1;
                        end
                        default: state <= S_IDLE;
                    endcase
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            op_q    <= cmd.cmd_op;
            addr_q  <= cmd.cmd_addr;
            wdata_q <= cmd.cmd_wdata;
        end
        if (slot_end)
        begin
            case (state)
                S_START:    shreg <= {eeprom_pkg::DEV_CODE, addr_q[10:8], 1'b0};
                S_RESTART:  shreg <= {eeprom_pkg::DEV_CODE, addr_q[10:8], 1'b1};
                S_BYTE_OUT: shreg <= {shreg[6:0], 1'b0};
                S_BYTE_IN:  shreg <= {shreg[6:0], sda_in};
                S_ACK_IN:
                    if (byte_idx == 2'd0)
                        shreg <= addr_q[7:0];
                    else if (byte_idx == 2'd1)
                        shreg <= wdata_q;   // read path reloads at restart
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/xfer_result.sv ====
`timescale 1ns/1ps
`default_nettype none

module xfer_result (
    input  logic                 CLK,
    input  logic                 RESET,
    eeprom_cmd_if.result         res,
    input  logic                 st_clear,
    output logic                 st_busy,
    output logic                 st_done,
    output logic                 st_nack,
    output eeprom_pkg::ee_byte_t st_rdata
);
    logic is_read;  // op of the transfer in flight

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            st_busy <= 1'b0;
            st_done <= 1'b0;
            st_nack <= 1'b0;
        end
        else
        begin
            if (res.cmd_valid && res.cmd_ready)
                st_busy <= 1'b1;
            else if (res.done_pulse)
                st_busy <= 1'b0;

            if (res.done_pulse)
            begin
                st_done <= 1'b1;
                st_nack <= res.done_nack;
            end
            else if (st_clear)
            begin
                st_done <= 1'b0;
                st_nack <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (res.cmd_valid && res.cmd_ready)
            is_read <= (res.cmd_op == eeprom_pkg::OP_READ);
        if (res.done_pulse && is_read)
            st_rdata <= res.done_rdata;
    end

endmodule

`default_nettype wire

// ==== source/eeprom_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module eeprom_ctrl_top #(
    parameter int CLK_DIV = 4
) (
    input  logic                   CLK,
    input  logic                   RESET,
    input  eeprom_pkg::axil_addr_t s_awaddr,
    input  logic                   s_awvalid,
    output logic                   s_awready,
    input  eeprom_pkg::axil_data_t s_wdata,
    input  logic [3:0]             s_wstrb,
    input  logic                   s_wvalid,
    output logic                   s_wready,
    output logic [1:0]             s_bresp,
    output logic                   s_bvalid,
    input  logic                   s_bready,
    input  eeprom_pkg::axil_addr_t s_araddr,
    input  logic                   s_arvalid,
    output logic                   s_arready,
    output eeprom_pkg::axil_data_t s_rdata,
    output logic [1:0]             s_rresp,
    output logic                   s_rvalid,
    input  logic                   s_rready,
    output logic                   scl,
    output logic                   sda_oe,   // high pulls sda low
    input  logic                   sda_in
);
    logic                 st_busy;
    logic                 st_done;
    logic                 st_nack;
    logic                 st_clear;
    eeprom_pkg::ee_byte_t st_rdata;

    eeprom_cmd_if cmd_bus ();

    axil_reg_decode u_decode (
        .CLK       (CLK),
        .RESET     (RESET),
        .s_awaddr  (s_awaddr),
        .s_awvalid (s_awvalid),
        .s_awready (s_awready),
        .s_wdata   (s_wdata),
        .s_wstrb   (s_wstrb),
        .s_wvalid  (s_wvalid),
        .s_wready  (s_wready),
        .s_bresp   (s_bresp),
        .s_bvalid  (s_bvalid),
        .s_bready  (s_bready),
        .s_araddr  (s_araddr),
        .s_arvalid (s_arvalid),
        .s_arready (s_arready),
        .s_rdata   (s_rdata),
        .s_rresp   (s_rresp),
        .s_rvalid  (s_rvalid),
        .s_rready  (s_rready),
        .cmd       (cmd_bus.decode),
        .st_busy   (st_busy),
        .st_done   (st_done),
        .st_nack   (st_nack),
        .st_rdata  (st_rdata),
        .st_clear  (st_clear)
    );

    twi_bit_engine #(
        .CLK_DIV (CLK_DIV)
    ) u_engine (
        .CLK    (CLK),
        .RESET  (RESET),
        .cmd    (cmd_bus.engine),
        .scl    (scl),
        .sda_oe (sda_oe),
        .sda_in (sda_in)
    );

    xfer_result u_result (
        .CLK      (CLK),
        .RESET    (RESET),
        .res      (cmd_bus.result),
        .st_clear (st_clear),
        .st_busy  (st_busy),
        .st_done  (st_done),
        .st_nack  (st_nack),
        .st_rdata (st_rdata)
    );

endmodule

`default_nettype wire

// ==== testbench/eeprom_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module eeprom_model (
    input  logic scl,
    input  logic sda,
    input  logic ack_en,
    output logic pull      // high pulls sda low
);
    typedef enum {M_IDLE, M_RX, M_ACK, M_TX, M_MACK} mstate_t;

    mstate_t     state;
    logic [7:0]  mem [0:2047];
    logic [7:0]  sh;
    logic [10:0] addr;
    logic        rw;
    int          cnt;
    int          byte_no;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'hFF;
        pull  = 1'b0;
        state = M_IDLE;
        rw    = 1'b0;
        addr  = '0;
    end

    always @(negedge sda)
    begin
        if (scl === 1'b1)  // start or repeated start
        begin
            state   = M_RX;
            cnt     = 0;
            byte_no = 0;
            pull    = 1'b0;
        end
    end

    always @(posedge sda)
    begin
        if (scl === 1'b1)
        begin
            state = M_IDLE;
            pull  = 1'b0;
        end
    end

    always @(posedge scl)
    begin
        if (state == M_RX)
        begin
            sh  = {sh[6:0], sda};
            cnt = cnt + 1;
        end
        else if (state == M_TX)
            cnt = cnt + 1;
    end

    always @(negedge scl)
    begin
        case (state)
            M_RX:
                if (cnt == 8)
                begin
                    case (byte_no)
                        0:
                        begin
                            addr[10:8] = sh[3:1];
                            rw         = sh[0];
                        end
                        1:       addr[7:0] = sh;
                        default: if (ack_en) mem[addr] = sh;
                    endcase
                    byte_no = byte_no + 1;
                    cnt     = 0;
                    pull    = ack_en;
                    state   = M_ACK;
                end
            M_ACK:
                if (rw && ack_en)
                begin
                    sh    = mem[addr];
                    pull  = ~sh[7];
                    cnt   = 0;
                    state = M_TX;
                end
                else
                begin
                    pull  = 1'b0;
                    state = M_RX;
                end
            M_TX:
                if (cnt == 8)
                begin
                    pull  = 1'b0;   // master answers nack
                    state = M_MACK;
                end
                else
                    pull = ~sh[7 - cnt];
            M_MACK: state = M_IDLE;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== testbench/eeprom_ctrl_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module eeprom_ctrl_assert (
    input logic       CLK,
    input logic       RESET,
    input logic       scl,
    input logic       sda_oe,
    input logic [2:0] state,
    input logic       cmd_valid,
    input logic       cmd_ready
);
    localparam logic [2:0] ST_IDLE    = 3'd0;
    localparam logic [2:0] ST_START   = 3'd1;
    localparam logic [2:0] ST_RESTART = 3'd4;
    localparam logic [2:0] ST_STOP    = 3'd7;

    a_sda_stable: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && sda_oe != $past(sda_oe))
            |-> (state == ST_START || state == ST_RESTART || state == ST_STOP))
        else $error("sda moved while scl high outside start, restart or stop");

    a_idle_scl: assert property (@(posedge CLK) disable iff (RESET)
        (state == ST_IDLE) |-> scl)
        else $error("scl low while engine idle");

    a_valid_hold: assert property (@(posedge CLK) disable iff (RESET)
        (cmd_valid && !cmd_ready) |=> cmd_valid)
        else $error("cmd_valid dropped before cmd_ready");

endmodule

bind twi_bit_engine eeprom_ctrl_assert u_assert (
    .CLK       (CLK),
    .RESET     (RESET),
    .scl       (scl),
    .sda_oe    (sda_oe),
    .state     (state),
    .cmd_valid (cmd.cmd_valid),
    .cmd_ready (cmd.cmd_ready)
);

`default_nettype wire

// ==== testbench/tb_eeprom_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_eeprom_ctrl;
    localparam int CLK_DIV = 4;
    localparam int LIMIT   = 40 * 39 * 2 * CLK_DIV + 5000;

    logic                   CLK = 1'b0;
    logic                   RESET;
    eeprom_pkg::axil_addr_t s_awaddr;
    logic                   s_awvalid;
    logic                   s_awready;
    eeprom_pkg::axil_data_t s_wdata;
    logic [3:0]             s_wstrb;
    logic                   s_wvalid;
    logic                   s_wready;
    logic [1:0]             s_bresp;
    logic                   s_bvalid;
    logic                   s_bready;
    eeprom_pkg::axil_addr_t s_araddr;
    logic                   s_arvalid;
    logic                   s_arready;
    eeprom_pkg::axil_data_t s_rdata;
    logic [1:0]             s_rresp;
    logic                   s_rvalid;
    logic                   s_rready;
    logic                   scl;
    logic                   sda_oe;
    logic                   model_pull;
    logic                   ack_en;
    wire                    sda = !(sda_oe || model_pull);   // wired and

    eeprom_pkg::ee_byte_t   shadow [0:2047];
    int                     cycles = 0;

    eeprom_ctrl_top #(.CLK_DIV(CLK_DIV)) uut (
        .CLK(CLK), .RESET(RESET),
        .s_awaddr(s_awaddr), .s_awvalid(s_awvalid), .s_awready(s_awready),
        .s_wdata(s_wdata), .s_wstrb(s_wstrb), .s_wvalid(s_wvalid), .s_wready(s_wready),
        .s_bresp(s_bresp), .s_bvalid(s_bvalid), .s_bready(s_bready),
        .s_araddr(s_araddr), .s_arvalid(s_arvalid), .s_arready(s_arready),
        .s_rdata(s_rdata), .s_rresp(s_rresp), .s_rvalid(s_rvalid), .s_rready(s_rready),
        .scl(scl), .sda_oe(sda_oe), .sda_in(sda)
    );

    eeprom_model u_model (.scl(scl), .sda(sda), .ack_en(ack_en), .pull(model_pull));

    always #5 CLK = ~CLK;

    always @(posedge CLK)
    begin
        cycles <= cycles + 1;
        if (cycles > LIMIT)
        begin
            $display("timeout: no result after %0d cycles", cycles);
            $display("TB FAILED");
            $fatal(1, "run stopped");
        end
    end

    function automatic eeprom_pkg::ee_byte_t ref_read(eeprom_pkg::ee_addr_t a);
        return shadow[a];
    endfunction

    task automatic report_error(string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        $display("TB FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_byte(string what, eeprom_pkg::ee_byte_t got, eeprom_pkg::ee_byte_t exp);
        if (got !== exp)
            report_error($sformatf("%s got %h expected %h", what, got, exp));
    endtask

    task automatic check_flag(string what, logic got, logic exp);
        if (got !== exp)
            report_error($sformatf("%s got %b expected %b", what, got, exp));
    endtask

    task automatic check_resp(string what, logic [1:0] got, logic [1:0] exp);
        if (got !== exp)
            report_error($sformatf("%s response %b expected %b", what, got, exp));
    endtask

    task automatic axi_write(eeprom_pkg::axil_addr_t a, eeprom_pkg::axil_data_t d, int hold,
                             output logic [1:0] resp);
        s_awaddr  = a;
        s_wdata   = d;
        s_wstrb   = 4'hF;
        s_awvalid = 1'b1;
        s_wvalid  = 1'b1;
        while (!s_awready)
        begin
            @(posedge CLK);
            #1;
        end
        check_flag("wready with awready", s_wready, 1'b1);
        @(posedge CLK);
        #1;
        s_awvalid = 1'b0;
        s_wvalid  = 1'b0;
        while (!s_bvalid)
        begin
            @(posedge CLK);
            #1;
        end
        repeat (hold)   // late bready
        begin
            @(posedge CLK);
            #1;
            check_flag("bvalid held", s_bvalid, 1'b1);
        end
        resp     = s_bresp;
        s_bready = 1'b1;
        @(posedge CLK);
        #1;
        s_bready = 1'b0;
    endtask

    task automatic axi_read(eeprom_pkg::axil_addr_t a, output eeprom_pkg::axil_data_t d,
                            output logic [1:0] resp);
        s_araddr  = a;
        s_arvalid = 1'b1;
        while (!s_arready)
        begin
            @(posedge CLK);
            #1;
        end
        @(posedge CLK);
        #1;
        s_arvalid = 1'b0;
        while (!s_rvalid)
        begin
            @(posedge CLK);
            #1;
        end
        d        = s_rdata;
        resp     = s_rresp;
        s_rready = 1'b1;
        @(posedge CLK);
        #1;
        s_rready = 1'b0;
    endtask

    task automatic wait_done(output eeprom_pkg::axil_data_t st);
        logic [1:0] r;
        st = '0;
        while (!st[1])
        begin
            axi_read(eeprom_pkg::REG_STATUS, st, r);
            check_resp("status poll", r, 2'b00);
        end
    endtask

    // one transfer and the status read that clears done
    task automatic run_xfer(eeprom_pkg::ee_addr_t a, eeprom_pkg::ee_byte_t d, logic is_read,
                            output eeprom_pkg::axil_data_t st);
        logic [1:0]             r;
        eeprom_pkg::axil_data_t st2;
        axi_write(eeprom_pkg::REG_ADDR, 32'(a), 0, r);
        check_resp("addr write", r, 2'b00);
        axi_write(eeprom_pkg::REG_WDATA, 32'(d), 0, r);
        check_resp("wdata write", r, 2'b00);
        axi_write(eeprom_pkg::REG_CTRL, is_read ? 32'h2 : 32'h1, 0, r);
        check_resp("ctrl write", r, 2'b00);
        wait_done(st);
        if (!is_read && ack_en)
            shadow[a] = d;
        axi_read(eeprom_pkg::REG_STATUS, st2, r);
        check_flag("done cleared", st2[1], 1'b0);
        check_flag("busy after done", st2[0], 1'b0);
    endtask

    initial
    begin
        eeprom_pkg::axil_data_t st;
        eeprom_pkg::ee_addr_t   addrs [12];
        eeprom_pkg::ee_addr_t   a;
        logic [1:0]             r;
        void'($urandom(32'h349));
        for (int i = 0; i < 2048; i++)
            shadow[i] = 8'hFF;
        RESET     = 1'b1;
        s_awaddr  = '0;
        s_awvalid = 1'b0;
        s_wdata   = '0;
        s_wstrb   = '0;
        s_wvalid  = 1'b0;
        s_bready  = 1'b0;
        s_araddr  = '0;
        s_arvalid = 1'b0;
        s_rready  = 1'b0;
        ack_en    = 1'b1;
        repeat (2) @(posedge CLK);
        #1;
        RESET = 1'b0;

        check_flag("scl after reset", scl, 1'b1);
        check_flag("sda_oe after reset", sda_oe, 1'b0);
        axi_read(eeprom_pkg::REG_STATUS, st, r);
        check_resp("status after reset", r, 2'b00);
        if (st !== '0)
            report_error($sformatf("status after reset %h", st));

        for (int i = 0; i < 12; i++)
        begin
            addrs[i] = {3'(i), 8'($urandom)};   // every upper address value
            run_xfer(addrs[i], 8'($urandom), 1'b0, st);
            check_flag("write nack", st[2], 1'b0);
        end
        for (int i = 0; i < 12; i++)
        begin
            run_xfer(addrs[i], 8'h00, 1'b1, st);
            check_flag("read nack", st[2], 1'b0);
            check_byte("read byte", st[15:8], ref_read(addrs[i]));
        end

        a = 11'h7FF;
        while (ref_read(a) !== 8'hFF)
            a = a - 1'b1;
        run_xfer(a, 8'h00, 1'b1, st);
        check_byte("unwritten byte", st[15:8], 8'hFF);

        ack_en = 1'b0;
        a = addrs[3];
        run_xfer(a, ~ref_read(a), 1'b0, st);
        check_flag("missing ack nack", st[2], 1'b1);
        ack_en = 1'b1;
        run_xfer(a, 8'h00, 1'b1, st);
        check_byte("memory after nack", st[15:8], ref_read(a));

        a = addrs[5];
        axi_write(eeprom_pkg::REG_ADDR, 32'(a), 0, r);
        axi_write(eeprom_pkg::REG_WDATA, 32'h5A, 0, r);
        axi_write(eeprom_pkg::REG_CTRL, 32'h1, 0, r);
        check_resp("first ctrl", r, 2'b00);
        axi_write(eeprom_pkg::REG_WDATA, 32'hA5, 0, r);   // a second write would store this
        check_resp("wdata while busy", r, 2'b00);
        axi_write(eeprom_pkg::REG_CTRL, 32'h1, 0, r);
        check_resp("ctrl while busy", r, 2'b10);
        wait_done(st);
        shadow[a] = 8'h5A;
        run_xfer(a, 8'h00, 1'b1, st);
        check_byte("after dropped ctrl", st[15:8], ref_read(a));

        axi_write(eeprom_pkg::REG_WDATA, 32'hC3, 6, r);
        check_resp("late bready", r, 2'b00);
        axi_write(eeprom_pkg::REG_ADDR, 32'h2A5, 0, r);
        check_resp("write after late bready", r, 2'b00);
        axi_read(eeprom_pkg::REG_ADDR, st, r);
        if (st !== 32'h2A5)
            report_error($sformatf("addr readback %h", st));
        axi_read(eeprom_pkg::REG_WDATA, st, r);
        check_byte("wdata readback", st[7:0], 8'hC3);

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
source/eeprom_pkg.sv
source/eeprom_cmd_if.sv
source/axil_reg_decode.sv
source/twi_bit_engine.sv
source/xfer_result.sv
source/eeprom_ctrl_top.sv
testbench/eeprom_model.sv
testbench/eeprom_ctrl_assert.sv
testbench/tb_eeprom_ctrl.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_eeprom_ctrl -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

./obj_dir/Vtb_eeprom_ctrl > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "TB FAILED" sim.log; then
    exit 1
fi
exit 0
